// File: design/dcache_settings.svh
// ====================
// Data cache settings
// Widths of the line index, the byte address, the data word
// and the stored line entry
// ====================
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Line index bits, 16 lines by default
`define DCACHE_INDEX_BITS 4

// Byte address width
`define DCACHE_ADDR_WIDTH 32

// Data word width
`define DCACHE_DATA_WIDTH 32

// Stored entry holds the data word above the address and flag bits
`define DCACHE_LINE_WIDTH 64

`endif

// File: design/apb_pkg.sv
// ====================
// APB types
// Opcode of a bus request and the phases of an APB transfer
// ====================
`default_nettype none

package apb_pkg;

	// Opcode handed from the cache controller to the bus master
	typedef enum logic {
		BUS_READ,
		BUS_WRITE
	} bus_op_t;

	// Transfer phases as seen on psel and penable
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_SETUP,
		PH_ACCESS
	} apb_phase_t;

endpackage

`default_nettype wire

// File: design/dcache_ctrl_pkg.sv
// ====================
// Data cache controller types
// State encoding of the controller and bit positions
// of the fields inside a stored line entry
// ====================
`default_nettype none

`include "dcache_settings.svh"

package dcache_ctrl_pkg;

	typedef enum logic [3:0] {
		ST_INIT,
		ST_IDLE,
		ST_PASS,
		ST_WRITE_CHECK,
		ST_WRITE_WB,
		ST_READ_CHECK,
		ST_READ_WB,
		ST_READ_FILL,
		ST_FLUSH_SETUP,
		ST_FLUSH_CHECK,
		ST_FLUSH_WB
	} ctrl_state_t;

	// Entry layout, word address sits between DIRTY_BIT and DATA_LSB
	localparam int VALID_BIT = 0;
	localparam int DIRTY_BIT = 1;
	localparam int DATA_LSB = `DCACHE_LINE_WIDTH - `DCACHE_DATA_WIDTH;

endpackage

`default_nettype wire

// File: design/dcache_line_ram.sv
// ====================
// Data cache line RAM
// Single-port entry storage, registered read, synchronous write
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_line_ram #(
	parameter int DEPTH_BITS = `DCACHE_INDEX_BITS
) (
	input wire i_clock,
	input wire logic i_write,
	input wire [DEPTH_BITS-1:0] i_address,
	input wire [`DCACHE_LINE_WIDTH-1:0] i_wdata,
	output logic [`DCACHE_LINE_WIDTH-1:0] o_rdata
);

	logic [`DCACHE_LINE_WIDTH-1:0] entries [0:(1 << DEPTH_BITS)-1];

	// Read returns the old entry when the same line is written
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			entries[i_address] <= i_wdata;
		end
		o_rdata <= entries[i_address];
	end

	// A stored line is never dirty without being valid
	a_entry_write: assert property (@(posedge i_clock)
		i_write |-> !$isunknown(i_address) &&
			(i_wdata[dcache_ctrl_pkg::VALID_BIT] || !i_wdata[dcache_ctrl_pkg::DIRTY_BIT]))
		else $error("line RAM write with unknown address or dirty invalid entry");

endmodule

`default_nettype wire

// File: design/apb_master.sv
// ====================
// APB master
// Runs one controller bus request as a setup and access phase
// and returns read data with a one-cycle done pulse
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module apb_master (
	input wire i_clock,
	input wire i_reset,

	// Controller side
	input wire i_bus_request,
	input wire apb_pkg::bus_op_t i_bus_op,
	input wire [`DCACHE_ADDR_WIDTH-1:0] i_bus_address,
	input wire [`DCACHE_DATA_WIDTH-1:0] i_bus_wdata,
	output logic o_bus_done,
	output logic [`DCACHE_DATA_WIDTH-1:0] o_bus_rdata,

	// APB
	output logic o_psel,
	output logic o_penable,
	output logic o_pwrite,
	output logic [`DCACHE_ADDR_WIDTH-1:0] o_paddr,
	output logic [`DCACHE_DATA_WIDTH-1:0] o_pwdata,
	input wire i_pready,
	input wire [`DCACHE_DATA_WIDTH-1:0] i_prdata
);

	apb_pkg::apb_phase_t phase;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			phase <= apb_pkg::PH_IDLE;
			o_psel <= 1'b0;
			o_penable <= 1'b0;
			o_bus_done <= 1'b0;
		end else begin
			o_bus_done <= 1'b0;
			case (phase)
				apb_pkg::PH_IDLE: begin
					// Request is still high in the cycle of the done pulse
					if (i_bus_request && !o_bus_done) begin
						o_paddr <= i_bus_address;
						o_pwrite <= (i_bus_op == apb_pkg::BUS_WRITE);
						o_pwdata <= i_bus_wdata;
						o_psel <= 1'b1;
						phase <= apb_pkg::PH_SETUP;
					end
				end
				apb_pkg::PH_SETUP: begin
					o_penable <= 1'b1;
					phase <= apb_pkg::PH_ACCESS;
				end
				apb_pkg::PH_ACCESS: begin
					if (i_pready) begin
						o_psel <= 1'b0;
						o_penable <= 1'b0;
						o_bus_rdata <= i_prdata;
						o_bus_done <= 1'b1;
						phase <= apb_pkg::PH_IDLE;
					end
				end
				default: phase <= apb_pkg::PH_IDLE;
			endcase
		end
	end

	a_setup_first: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_penable) |-> o_psel && $past(o_psel))
		else $error("penable raised without a setup phase");

endmodule

`default_nettype wire

// File: design/dcache_controller.sv
// ====================
// Data cache controller
// Direct-mapped write-back control with hit service from idle,
// victim write-back, line fill, uncached pass-through, flush,
// line clearing after reset and hit and miss counters
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_controller (
	input wire i_clock,
	input wire i_reset,

	// Core side
	input wire i_request,
	input wire i_rw,
	input wire i_flush,
	input wire i_cacheable,
	input wire [`DCACHE_ADDR_WIDTH-1:0] i_address,
	input wire [`DCACHE_DATA_WIDTH-1:0] i_wdata,
	output logic o_ready,
	output logic [`DCACHE_DATA_WIDTH-1:0] o_rdata,

	// Line RAM side
	output logic o_ram_write,
	output logic [`DCACHE_INDEX_BITS-1:0] o_ram_address,
	output logic [`DCACHE_LINE_WIDTH-1:0] o_ram_wdata,
	input wire [`DCACHE_LINE_WIDTH-1:0] i_ram_rdata,

	// Bus side
	output logic o_bus_request,
	output apb_pkg::bus_op_t o_bus_op,
	output logic [`DCACHE_ADDR_WIDTH-1:0] o_bus_address,
	output logic [`DCACHE_DATA_WIDTH-1:0] o_bus_wdata,
	input wire i_bus_done,
	input wire [`DCACHE_DATA_WIDTH-1:0] i_bus_rdata,

	// Counters
	output logic [31:0] o_hit,
	output logic [31:0] o_miss
);

	dcache_ctrl_pkg::ctrl_state_t state;
	logic [`DCACHE_INDEX_BITS-1:0] flush_index;

	logic entry_valid;
	logic entry_dirty;
	logic entry_hit;
	logic take;
	logic [`DCACHE_ADDR_WIDTH-1:0] entry_address;
	logic [`DCACHE_DATA_WIDTH-1:0] entry_data;

	function automatic logic [`DCACHE_LINE_WIDTH-1:0] make_entry(
		input logic [`DCACHE_DATA_WIDTH-1:0] data,
		input logic [`DCACHE_ADDR_WIDTH-1:0] address,
		input logic dirty
	);
		logic [`DCACHE_LINE_WIDTH-1:0] entry;
		entry = '0;
		entry[`DCACHE_LINE_WIDTH-1:dcache_ctrl_pkg::DATA_LSB] = data;
		entry[dcache_ctrl_pkg::DATA_LSB-1:2] = address[`DCACHE_ADDR_WIDTH-1:2];
		entry[dcache_ctrl_pkg::DIRTY_BIT] = dirty;
		entry[dcache_ctrl_pkg::VALID_BIT] = 1'b1;
		return entry;
	endfunction

	// Fields of the entry read in the previous cycle
	assign entry_valid = i_ram_rdata[dcache_ctrl_pkg::VALID_BIT];
	assign entry_dirty = i_ram_rdata[dcache_ctrl_pkg::DIRTY_BIT];
	assign entry_address = {i_ram_rdata[dcache_ctrl_pkg::DATA_LSB-1:2], 2'b00};
	assign entry_data = i_ram_rdata[`DCACHE_LINE_WIDTH-1:dcache_ctrl_pkg::DATA_LSB];
	assign entry_hit = entry_valid &&
		(entry_address[`DCACHE_ADDR_WIDTH-1:2] == i_address[`DCACHE_ADDR_WIDTH-1:2]);

	// New request, not the one just answered
	assign take = i_request && !o_ready;

	always_comb begin
		case (state)
			dcache_ctrl_pkg::ST_INIT,
			dcache_ctrl_pkg::ST_FLUSH_SETUP,
			dcache_ctrl_pkg::ST_FLUSH_CHECK,
			dcache_ctrl_pkg::ST_FLUSH_WB: o_ram_address = flush_index;
			default: o_ram_address = i_address[`DCACHE_INDEX_BITS+1:2];
		endcase
	end

	// Line writes, a dirty store unless stated otherwise
	always_comb begin
		o_ram_write = 1'b0;
		o_ram_wdata = make_entry(i_wdata, i_address, 1'b1);
		case (state)
			dcache_ctrl_pkg::ST_INIT: begin
				o_ram_write = 1'b1;
				o_ram_wdata = '0;
			end
			dcache_ctrl_pkg::ST_IDLE:
				o_ram_write = take && !i_flush && i_cacheable && i_rw && entry_hit;
			dcache_ctrl_pkg::ST_WRITE_CHECK: o_ram_write = entry_hit || !entry_dirty;
			dcache_ctrl_pkg::ST_WRITE_WB: o_ram_write = i_bus_done;
			dcache_ctrl_pkg::ST_READ_FILL: begin
				o_ram_write = i_bus_done;
				o_ram_wdata = make_entry(i_bus_rdata, i_address, 1'b0);
			end
			dcache_ctrl_pkg::ST_FLUSH_CHECK: begin
				o_ram_write = entry_dirty;
				o_ram_wdata = '0;
			end
			default: o_ram_write = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= dcache_ctrl_pkg::ST_INIT;
			flush_index <= '0;
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
			o_hit <= '0;
			o_miss <= '0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				// ====================
				// Clearing and idle
				// ====================
				dcache_ctrl_pkg::ST_INIT: begin
					flush_index <= flush_index + 1'b1;
					if (&flush_index) begin
						state <= dcache_ctrl_pkg::ST_IDLE;
					end
				end
				dcache_ctrl_pkg::ST_IDLE: begin
					if (take) begin
						if (i_flush) begin
							flush_index <= '0;
							state <= dcache_ctrl_pkg::ST_FLUSH_SETUP;
						end else if (i_cacheable && entry_hit) begin
							// Hot line, answer right away
							o_rdata <= entry_data;
							o_ready <= 1'b1;
							o_hit <= o_hit + 1'b1;
						end else if (i_cacheable) begin
							state <= i_rw ? dcache_ctrl_pkg::ST_WRITE_CHECK :
								dcache_ctrl_pkg::ST_READ_CHECK;
						end else begin
							o_bus_request <= 1'b1;
							o_bus_op <= i_rw ? apb_pkg::BUS_WRITE : apb_pkg::BUS_READ;
							o_bus_address <= i_address;
							o_bus_wdata <= i_wdata;
							state <= dcache_ctrl_pkg::ST_PASS;
						end
					end
				end
				dcache_ctrl_pkg::ST_PASS: begin
					if (i_bus_done) begin
						o_bus_request <= 1'b0;
						o_rdata <= i_bus_rdata;
						o_ready <= 1'b1;
						state <= dcache_ctrl_pkg::ST_IDLE;
					end
				end
				// ====================
				// Cached write
				// ====================
				dcache_ctrl_pkg::ST_WRITE_CHECK: begin
					if (entry_hit) begin
						o_hit <= o_hit + 1'b1;
					end else begin
						o_miss <= o_miss + 1'b1;
					end
					if (!entry_hit && entry_dirty) begin
						o_bus_request <= 1'b1;
						o_bus_op <= apb_pkg::BUS_WRITE;
						o_bus_address <= entry_address;
						o_bus_wdata <= entry_data;
						state <= dcache_ctrl_pkg::ST_WRITE_WB;
					end else begin
						o_ready <= 1'b1;
						state <= dcache_ctrl_pkg::ST_IDLE;
					end
				end
				dcache_ctrl_pkg::ST_WRITE_WB: begin
					if (i_bus_done) begin
						o_bus_request <= 1'b0;
						o_ready <= 1'b1;
						state <= dcache_ctrl_pkg::ST_IDLE;
					end
				end
				// ====================
				// Cached read
				// ====================
				dcache_ctrl_pkg::ST_READ_CHECK: begin
					if (entry_hit) begin
						o_hit <= o_hit + 1'b1;
						o_rdata <= entry_data;
						o_ready <= 1'b1;
						state <= dcache_ctrl_pkg::ST_IDLE;
					end else begin
						o_miss <= o_miss + 1'b1;
						o_bus_request <= 1'b1;
						if (entry_dirty) begin
							o_bus_op <= apb_pkg::BUS_WRITE;
							o_bus_address <= entry_address;
							o_bus_wdata <= entry_data;
							state <= dcache_ctrl_pkg::ST_READ_WB;
						end else begin
							o_bus_op <= apb_pkg::BUS_READ;
							o_bus_address <= i_address;
							state <= dcache_ctrl_pkg::ST_READ_FILL;
						end
					end
				end
				dcache_ctrl_pkg::ST_READ_WB: begin
					if (i_bus_done) begin
						o_bus_request <= 1'b0;
						state <= dcache_ctrl_pkg::ST_READ_FILL;
					end
				end
				dcache_ctrl_pkg::ST_READ_FILL: begin
					if (i_bus_done) begin
						o_bus_request <= 1'b0;
						o_rdata <= i_bus_rdata;
						o_ready <= 1'b1;
						state <= dcache_ctrl_pkg::ST_IDLE;
					end else if (!o_bus_request) begin
						// Fill read after the victim went out
						o_bus_request <= 1'b1;
						o_bus_op <= apb_pkg::BUS_READ;
						o_bus_address <= i_address;
					end
				end
				// ====================
				// Flush
				// ====================
				dcache_ctrl_pkg::ST_FLUSH_SETUP: state <= dcache_ctrl_pkg::ST_FLUSH_CHECK;
				dcache_ctrl_pkg::ST_FLUSH_CHECK: begin
					if (entry_dirty) begin
						o_bus_request <= 1'b1;
						o_bus_op <= apb_pkg::BUS_WRITE;
						o_bus_address <= entry_address;
						o_bus_wdata <= entry_data;
						state <= dcache_ctrl_pkg::ST_FLUSH_WB;
					end else if (&flush_index) begin
						o_ready <= 1'b1;
						state <= dcache_ctrl_pkg::ST_IDLE;
					end else begin
						flush_index <= flush_index + 1'b1;
						state <= dcache_ctrl_pkg::ST_FLUSH_SETUP;
					end
				end
				dcache_ctrl_pkg::ST_FLUSH_WB: begin
					if (i_bus_done) begin
						o_bus_request <= 1'b0;
						flush_index <= flush_index + 1'b1;
						if (&flush_index) begin
							o_ready <= 1'b1;
							state <= dcache_ctrl_pkg::ST_IDLE;
						end else begin
							state <= dcache_ctrl_pkg::ST_FLUSH_SETUP;
						end
					end
				end
				default: state <= dcache_ctrl_pkg::ST_IDLE;
			endcase
		end
	end

	a_ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |=> !o_ready)
		else $error("o_ready high for two cycles");

	a_bus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_done |=> o_bus_request)
		else $error("bus request dropped before bus done");

	// Every bus job ends before the controller is back in idle
	a_idle_no_bus: assert property (@(posedge i_clock) disable iff (i_reset)
		state == dcache_ctrl_pkg::ST_IDLE |-> !o_bus_request)
		else $error("bus request pending in idle");

endmodule

`default_nettype wire

// File: design/dcache_top.sv
// ====================
// Data cache top level
// Controller, line RAM and APB master
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
	input wire i_clock,
	input wire i_reset,

	// Core side
	input wire i_request,
	input wire i_rw,
	input wire i_flush,
	input wire i_cacheable,
	input wire [`DCACHE_ADDR_WIDTH-1:0] i_address,
	input wire [`DCACHE_DATA_WIDTH-1:0] i_wdata,
	output logic o_ready,
	output logic [`DCACHE_DATA_WIDTH-1:0] o_rdata,

	// APB
	output logic o_psel,
	output logic o_penable,
	output logic o_pwrite,
	output logic [`DCACHE_ADDR_WIDTH-1:0] o_paddr,
	output logic [`DCACHE_DATA_WIDTH-1:0] o_pwdata,
	input wire i_pready,
	input wire [`DCACHE_DATA_WIDTH-1:0] i_prdata,

	// Counters
	output logic [31:0] o_hit,
	output logic [31:0] o_miss
);

	logic ram_write;
	logic [`DCACHE_INDEX_BITS-1:0] ram_address;
	logic [`DCACHE_LINE_WIDTH-1:0] ram_wdata;
	logic [`DCACHE_LINE_WIDTH-1:0] ram_rdata;

	logic bus_request;
	apb_pkg::bus_op_t bus_op;
	logic [`DCACHE_ADDR_WIDTH-1:0] bus_address;
	logic [`DCACHE_DATA_WIDTH-1:0] bus_wdata;
	logic [`DCACHE_DATA_WIDTH-1:0] bus_rdata;
	logic bus_done;

	dcache_controller controller_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_flush(i_flush),
		.i_cacheable(i_cacheable),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_ram_write(ram_write),
		.o_ram_address(ram_address),
		.o_ram_wdata(ram_wdata),
		.i_ram_rdata(ram_rdata),
		.o_bus_request(bus_request),
		.o_bus_op(bus_op),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_bus_done(bus_done),
		.i_bus_rdata(bus_rdata),
		.o_hit(o_hit),
		.o_miss(o_miss)
	);

	dcache_line_ram #(
		.DEPTH_BITS(`DCACHE_INDEX_BITS)
	) line_ram_i (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata)
	);

	apb_master apb_master_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_request(bus_request),
		.i_bus_op(bus_op),
		.i_bus_address(bus_address),
		.i_bus_wdata(bus_wdata),
		.o_bus_done(bus_done),
		.o_bus_rdata(bus_rdata),
		.o_psel(o_psel),
		.o_penable(o_penable),
		.o_pwrite(o_pwrite),
		.o_paddr(o_paddr),
		.o_pwdata(o_pwdata),
		.i_pready(i_pready),
		.i_prdata(i_prdata)
	);

endmodule

`default_nettype wire

// File: tests/apb_memory_model.sv
// ====================
// APB memory model
// Word-wide slave memory with a known start pattern
// and random wait states taken from an LFSR
// ====================
`timescale 1ns/1ps
`default_nettype none

module apb_memory_model #(
	parameter int DEPTH_WORDS = 1024,
	parameter logic [31:0] SEED = 32'h55ef
) (
	input wire i_clock,
	input wire i_reset,
	input wire i_psel,
	input wire i_penable,
	input wire i_pwrite,
	input wire [31:0] i_paddr,
	input wire [31:0] i_pwdata,
	output logic o_pready,
	output logic [31:0] o_prdata
);

	localparam int WORD_BITS = $clog2(DEPTH_WORDS);

	logic [31:0] words [0:DEPTH_WORDS-1];
	logic [31:0] lfsr;
	logic [1:0] waits;
	logic [WORD_BITS-1:0] word_index;
	apb_pkg::apb_phase_t bus_phase;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] shift_lfsr(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	assign word_index = i_paddr[WORD_BITS+1:2];

	// Phase of the transfer as seen on psel and penable
	always_comb begin
		if (!i_psel) begin
			bus_phase = apb_pkg::PH_IDLE;
		end else if (!i_penable) begin
			bus_phase = apb_pkg::PH_SETUP;
		end else begin
			bus_phase = apb_pkg::PH_ACCESS;
		end
	end

	always @(posedge i_clock) begin : slave_seq
		logic [31:0] next_state;
		logic [1:0] draw;
		if (i_reset) begin
			// Start pattern is the word address XOR a fixed mask
			for (int i = 0; i < DEPTH_WORDS; i++) begin
				words[i] <= 32'(i) ^ 32'hA5A5_0000;
			end
			lfsr <= SEED;
			waits <= 2'd0;
			o_pready <= 1'b0;
			o_prdata <= '0;
		end else begin
			case (bus_phase)
				apb_pkg::PH_SETUP: begin
					// One LFSR step per bit of the wait count
					next_state = shift_lfsr(lfsr);
					draw[0] = next_state[0];
					next_state = shift_lfsr(next_state);
					draw[1] = next_state[0];
					lfsr <= next_state;
					waits <= draw;
					o_pready <= (draw == 2'd0);
					o_prdata <= words[word_index];
				end
				apb_pkg::PH_ACCESS: begin
					if (o_pready) begin
						// Transfer completes on this edge
						if (i_pwrite) begin
							words[word_index] <= i_pwdata;
						end
						o_pready <= 1'b0;
					end else begin
						waits <= waits - 2'd1;
						o_pready <= (waits == 2'd1);
					end
				end
				default: o_pready <= 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_dcache.sv
// ====================
// Data cache testbench
// Drives the core side, predicts cache and memory state
// and checks read data and the hit and miss counters
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module tb_dcache;

	localparam int LINES = 1 << `DCACHE_INDEX_BITS;
	localparam int MEM_WORDS = 1024;
	localparam int TIMEOUT_CYCLES = 500;
	localparam int RANDOM_OPS = 200;

	logic clock = 1'b0;
	logic reset;
	logic request;
	logic rw;
	logic flush;
	logic cacheable;
	logic [31:0] address;
	logic [31:0] wdata;
	logic ready;
	logic [31:0] rdata;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic pready;
	logic [31:0] prdata;
	logic [31:0] hit_count;
	logic [31:0] miss_count;

	// Shadow of the cache lines and of the memory
	logic line_valid [0:LINES-1];
	logic line_dirty [0:LINES-1];
	logic [29:0] line_word [0:LINES-1];
	logic [31:0] line_data [0:LINES-1];
	logic [31:0] shadow_mem [0:MEM_WORDS-1];
	int expected_hits;
	int expected_misses;

	// Predictions for requests in flight
	logic [31:0] expected_queue [$];
	logic check_queue [$];

	logic [31:0] lfsr_state = 32'h55ef;
	string test_name = "reset";
	logic timed_out = 1'b0;
	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;

	always #10 clock = ~clock;

	dcache_top dcache_top_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_rw(rw),
		.i_flush(flush),
		.i_cacheable(cacheable),
		.i_address(address),
		.i_wdata(wdata),
		.o_ready(ready),
		.o_rdata(rdata),
		.o_psel(psel),
		.o_penable(penable),
		.o_pwrite(pwrite),
		.o_paddr(paddr),
		.o_pwdata(pwdata),
		.i_pready(pready),
		.i_prdata(prdata),
		.o_hit(hit_count),
		.o_miss(miss_count)
	);

	apb_memory_model #(
		.DEPTH_WORDS(MEM_WORDS),
		.SEED(32'h55ef)
	) memory_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_psel(psel),
		.i_penable(penable),
		.i_pwrite(pwrite),
		.i_paddr(paddr),
		.i_pwdata(pwdata),
		.o_pready(pready),
		.o_prdata(prdata)
	);

	// ====================
	// Random numbers
	// ====================
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// ====================
	// Cache model
	// ====================
	function automatic logic [31:0] predict_access(
		input logic is_write,
		input logic is_cached,
		input logic is_flush,
		input logic [31:0] byte_address,
		input logic [31:0] data
	);
		int index;
		logic [29:0] word;
		logic [9:0] slot;
		logic hit;
		index = int'(byte_address[`DCACHE_INDEX_BITS+1:2]);
		word = byte_address[31:2];
		slot = byte_address[11:2];
		if (is_flush) begin
			// Dirty lines go to memory and are dropped while clean lines stay
			for (int i = 0; i < LINES; i++) begin
				if (line_valid[i] && line_dirty[i]) begin
					shadow_mem[line_word[i][9:0]] = line_data[i];
					line_valid[i] = 1'b0;
					line_dirty[i] = 1'b0;
				end
			end
			return '0;
		end
		if (!is_cached) begin
			if (is_write) begin
				shadow_mem[slot] = data;
			end
			return shadow_mem[slot];
		end
		hit = line_valid[index] && (line_word[index] == word);
		if (hit) begin
			expected_hits++;
		end else begin
			expected_misses++;
		end
		// Victim write-back
		if (!hit && line_valid[index] && line_dirty[index]) begin
			shadow_mem[line_word[index][9:0]] = line_data[index];
		end
		if (is_write) begin
			line_valid[index] = 1'b1;
			line_dirty[index] = 1'b1;
			line_word[index] = word;
			line_data[index] = data;
		end else if (!hit) begin
			line_valid[index] = 1'b1;
			line_dirty[index] = 1'b0;
			line_word[index] = word;
			line_data[index] = shadow_mem[slot];
		end
		return line_data[index];
	endfunction

	// ====================
	// Core side requests
	// ====================
	task automatic core_access(
		input logic is_write,
		input logic is_cached,
		input logic is_flush,
		input logic [31:0] byte_address,
		input logic [31:0] data
	);
		logic [31:0] expected;
		int cycles;
		if (!timed_out) begin
			expected = predict_access(is_write, is_cached, is_flush, byte_address, data);
			@(posedge clock);
			expected_queue.push_back(expected);
			check_queue.push_back(!is_write && !is_flush);
			request <= 1'b1;
			rw <= is_write;
			cacheable <= is_cached;
			flush <= is_flush;
			address <= byte_address;
			wdata <= data;
			cycles = 0;
			@(posedge clock);
			while (!ready && cycles < TIMEOUT_CYCLES) begin
				@(posedge clock);
				cycles++;
			end
			if (!ready) begin
				$display("timeout: no o_ready within %0d cycles in test %s", TIMEOUT_CYCLES,
					test_name);
				errors++;
				timed_out = 1'b1;
			end else begin
				request <= 1'b0;
				flush <= 1'b0;
			end
		end
	endtask

	// Read data is stable in the middle of the ready cycle
	always @(negedge clock) begin : compare_reads
		logic [31:0] expected;
		logic checked;
		if (!reset && ready) begin
			if (expected_queue.size() == 0) begin
				$display("%s: o_ready pulsed with no request outstanding", test_name);
				errors++;
			end else begin
				expected = expected_queue.pop_front();
				checked = check_queue.pop_front();
				if (checked && rdata !== expected) begin
					$display("error %s: read data expected %h, actual %h", test_name,
						expected, rdata);
					errors++;
				end
			end
		end
	end

	task automatic compare_counters();
		if (hit_count !== 32'(expected_hits)) begin
			$display("error %s: hit count expected %0d, actual %0d", test_name,
				expected_hits, hit_count);
			errors++;
		end
		if (miss_count !== 32'(expected_misses)) begin
			$display("error %s: miss count expected %0d, actual %0d", test_name,
				expected_misses, miss_count);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		compare_counters();
		if (errors == errors_at_start) begin
			$display("test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s FAILED with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	// ====================
	// Stimulus
	// ====================
	initial begin
		logic [31:0] random_value;
		logic [31:0] random_address;
		logic random_write;
		logic random_cached;
		reset = 1'b1;
		request = 1'b0;
		rw = 1'b0;
		flush = 1'b0;
		cacheable = 1'b0;
		address = '0;
		wdata = '0;
		expected_hits = 0;
		expected_misses = 0;
		for (int i = 0; i < LINES; i++) begin
			line_valid[i] = 1'b0;
			line_dirty[i] = 1'b0;
			line_word[i] = '0;
			line_data[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow_mem[i] = 32'(i) ^ 32'hA5A5_0000;
		end
		repeat (10) @(posedge clock);
		reset <= 1'b0;

		start_test("read_after_reset");
		core_access(1'b0, 1'b1, 1'b0, 32'h0000_0040, '0);
		compare_counters();
		core_access(1'b0, 1'b1, 1'b0, 32'h0000_0040, '0);
		end_test();

		start_test("write_then_read");
		core_access(1'b1, 1'b1, 1'b0, 32'h0000_0084, 32'h1234_5678);
		core_access(1'b0, 1'b1, 1'b0, 32'h0000_0084, '0);
		// Memory still holds the old word while the line is dirty
		core_access(1'b0, 1'b0, 1'b0, 32'h0000_0084, '0);
		end_test();

		start_test("conflict_eviction");
		core_access(1'b1, 1'b1, 1'b0, 32'h0000_0108, 32'hCAFE_0108);
		core_access(1'b1, 1'b1, 1'b0, 32'h0000_0148, 32'hBEEF_0148);
		core_access(1'b0, 1'b0, 1'b0, 32'h0000_0108, '0);
		end_test();

		start_test("uncached_access");
		core_access(1'b1, 1'b0, 1'b0, 32'h0000_0200, 32'h0F0F_1234);
		core_access(1'b0, 1'b0, 1'b0, 32'h0000_0200, '0);
		core_access(1'b0, 1'b0, 1'b0, 32'h0000_0204, '0);
		end_test();

		start_test("flush");
		for (int i = 0; i < 4; i++) begin
			core_access(1'b1, 1'b1, 1'b0, 32'h0000_0300 + 32'(i * 4), 32'h7700_0000 + 32'(i));
		end
		core_access(1'b0, 1'b1, 1'b1, '0, '0);
		for (int i = 0; i < 4; i++) begin
			core_access(1'b0, 1'b0, 1'b0, 32'h0000_0300 + 32'(i * 4), '0);
		end
		core_access(1'b0, 1'b0, 1'b0, 32'h0000_0148, '0);
		core_access(1'b0, 1'b1, 1'b0, 32'h0000_0304, '0);
		end_test();

		start_test("random_traffic");
		for (int n = 0; n < RANDOM_OPS; n++) begin
			draw_bits(6, random_value);
			random_address = 32'h0000_0800 + {random_value[29:0], 2'b00};
			draw_bits(1, random_value);
			random_write = random_value[0];
			// Three in four requests are cacheable
			draw_bits(2, random_value);
			random_cached = (random_value[1:0] != 2'b00);
			draw_bits(32, random_value);
			core_access(random_write, random_cached, 1'b0, random_address, random_value);
		end
		end_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/apb_pkg.sv
design/dcache_ctrl_pkg.sv
design/dcache_line_ram.sv
design/apb_master.sv
design/dcache_controller.sv
design/dcache_top.sv
tests/apb_memory_model.sv
tests/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the data cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_dcache -o tb_dcache_sim

output=$(./obj_dir/tb_dcache_sim)
echo "$output"
if echo "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
